// ==== hdl/zzcpu.sv ====
`timescale 1ns/1ns
`include "zzcpu_params.svh"

module zzcpu
	import zzcpu_pipe_pkg::*;
(
	input  logic                      clk,
	input  logic                      arst_n_i,
	output logic [`ZZCPU_PC_W-1:0]    imem_addr_o,
	input  logic [`ZZCPU_XLEN-1:0]    imem_data_i,
	output logic [`ZZCPU_DADDR_W-1:0] ram1_addr_o,
	output logic [`ZZCPU_XLEN-1:0]    ram1_wdata_o,
	input  logic [`ZZCPU_XLEN-1:0]    ram1_rdata_i,
	output logic                      ram1_oe_n_o,
	output logic                      ram1_we_n_o,
	output logic [`ZZCPU_XLEN-1:0]    light_o
);

	// decode to id/ex, id/ex to execute
	idex_t                    idex_dec;
	idex_t                    idex_ex;
	logic                     stall;
	exmem_t                   exmem;
	wb_t                      wb;
	// register file read ports
	logic [`ZZCPU_REG_AW-1:0] rd_idx1;
	logic [`ZZCPU_REG_AW-1:0] rd_idx2;
	logic [`ZZCPU_XLEN-1:0]   rd_data1;
	logic [`ZZCPU_XLEN-1:0]   rd_data2;

	////////////////////////////////////////////////////////////
	// stages
	////////////////////////////////////////////////////////////
	zzcpu_fetch_decode fetch_decode_i (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.imem_addr_o (imem_addr_o),
		.imem_data_i (imem_data_i),
		.rd_idx1_o   (rd_idx1),
		.rd_idx2_o   (rd_idx2),
		.rd_data1_i  (rd_data1),
		.rd_data2_i  (rd_data2),
		.idex_fb_i   (idex_ex),
		.idex_o      (idex_dec),
		.stall_o     (stall)
	);

	zzcpu_regheap regheap_i (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.rd_idx1_i  (rd_idx1),
		.rd_idx2_i  (rd_idx2),
		.rd_data1_o (rd_data1),
		.rd_data2_o (rd_data2),
		.wb_i       (wb)
	);

	zzcpu_id_ex id_ex_i (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.idex_i   (idex_dec),
		.stall_i  (stall),
		.idex_o   (idex_ex)
	);

	// ex/mem feedback copy left open, load-use watches id/ex instead
	zzcpu_execute execute_i (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.idex_i     (idex_ex),
		.exmem_fb_o (),
		.wb_i       (wb),
		.exmem_o    (exmem)
	);

	zzcpu_memory_wb memory_wb_i (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.exmem_i      (exmem),
		.ram1_addr_o  (ram1_addr_o),
		.ram1_wdata_o (ram1_wdata_o),
		.ram1_rdata_i (ram1_rdata_i),
		.ram1_oe_n_o  (ram1_oe_n_o),
		.ram1_we_n_o  (ram1_we_n_o),
		.light_o      (light_o),
		.wb_o         (wb)
	);

endmodule

// ==== hdl/zzcpu_execute.sv ====
`timescale 1ns/1ns
`include "zzcpu_params.svh"

module zzcpu_execute
	import zzcpu_pipe_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n_i,
	input  idex_t  idex_i,
	output exmem_t exmem_fb_o,
	input  wb_t    wb_i,
	output exmem_t exmem_o
);

	exmem_t                 exmem_q;
	exmem_t                 exmem_d;
	logic [`ZZCPU_XLEN-1:0] a_val;
	logic [`ZZCPU_XLEN-1:0] b_val;
	logic [`ZZCPU_XLEN-1:0] st_val;
	logic [`ZZCPU_XLEN-1:0] alu_res;

	////////////////////////////////////////////////////////////
	// forwarding
	////////////////////////////////////////////////////////////

	// nearer stage first
	// a load in ex/mem has no data yet, decode stalls that case
	function automatic logic [`ZZCPU_XLEN-1:0] fwd(
		input logic [`ZZCPU_REG_AW-1:0] name,
		input logic [`ZZCPU_XLEN-1:0]   value,
		input exmem_t                   near,
		input wb_t                      far
	);
		if (near.valid && near.regwrite && !near.memread && (near.rd == name)) begin
			return near.result;
		end
		if (far.en && (far.rd == name)) begin
			return far.data;
		end
		return value;
	endfunction

	always_comb begin
		a_val  = idex_i.opa;
		b_val  = idex_i.opb;
		st_val = idex_i.st_data;
		if (idex_i.rs1_used) begin
			a_val = fwd(idex_i.rs1, idex_i.opa, exmem_q, wb_i);
		end
		// store address from the first store half
		if (idex_i.b_prev) begin
			b_val = exmem_q.result;
		end else if (idex_i.rs2_used) begin
			b_val = fwd(idex_i.rs2, idex_i.opb, exmem_q, wb_i);
		end
		if (idex_i.memwrite) begin
			st_val = fwd(idex_i.rs_st, idex_i.st_data, exmem_q, wb_i);
		end
	end

	////////////////////////////////////////////////////////////
	// alu, wraps at word width
	////////////////////////////////////////////////////////////
	always_comb begin
		case (idex_i.aluop)
			ALU_ADD: alu_res = a_val + b_val;
			ALU_SUB: alu_res = a_val - b_val;
			ALU_AND: alu_res = a_val & b_val;
			ALU_OR:  alu_res = a_val | b_val;
			default: alu_res = b_val;
		endcase
	end

	always_comb begin
		exmem_d          = '0;
		exmem_d.valid    = idex_i.valid;
		exmem_d.regwrite = idex_i.regwrite;
		exmem_d.memread  = idex_i.memread;
		exmem_d.memwrite = idex_i.memwrite;
		exmem_d.result   = alu_res;
		exmem_d.st_data  = st_val;
		exmem_d.rd       = idex_i.rd;
	end

	// ex/mem register
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			exmem_q <= '0;
		end else begin
			exmem_q <= exmem_d;
		end
	end

	assign exmem_o    = exmem_q;
	assign exmem_fb_o = exmem_q;

endmodule

// ==== hdl/zzcpu_fetch_decode.sv ====
`timescale 1ns/1ns
`include "zzcpu_params.svh"

module zzcpu_fetch_decode
	import zzcpu_isa_pkg::*;
	import zzcpu_pipe_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n_i,
	output logic [`ZZCPU_PC_W-1:0]   imem_addr_o,
	input  logic [`ZZCPU_XLEN-1:0]   imem_data_i,
	output logic [`ZZCPU_REG_AW-1:0] rd_idx1_o,
	output logic [`ZZCPU_REG_AW-1:0] rd_idx2_o,
	input  logic [`ZZCPU_XLEN-1:0]   rd_data1_i,
	input  logic [`ZZCPU_XLEN-1:0]   rd_data2_i,
	input  idex_t                    idex_fb_i,
	output idex_t                    idex_o,
	output logic                     stall_o
);

	logic [`ZZCPU_PC_W-1:0] pc_q;
	instr_u                 ifid_q;
	// second half of a store in decode
	logic                   sw_phase_q;
	logic                   is_sw;
	logic                   hold;
	logic [`ZZCPU_XLEN-1:0] imm_zext;
	logic [`ZZCPU_XLEN-1:0] imm_sext;
	logic                   hit1;
	logic                   hit2;

	////////////////////////////////////////////////////////////
	// fetch
	////////////////////////////////////////////////////////////
	assign imem_addr_o = pc_q;

	// pc and if/id freeze on load-use and on first store half
	assign hold = stall_o | (is_sw & ~sw_phase_q);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q       <= '0;
			ifid_q     <= '0;
			sw_phase_q <= 1'b0;
		end else begin
			if (!hold) begin
				pc_q   <= pc_q + {{(`ZZCPU_PC_W-1){1'b0}}, 1'b1};
				ifid_q <= imem_data_i;
			end
			if (!stall_o) begin
				sw_phase_q <= is_sw & ~sw_phase_q;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////
	assign is_sw    = (ifid_q.rrr.opcode == OP_SW);
	assign imm_zext = {{(`ZZCPU_XLEN-8){1'b0}}, ifid_q.ri.imm};
	assign imm_sext = {{(`ZZCPU_XLEN-8){ifid_q.ri.imm[7]}}, ifid_q.ri.imm};

	// ri.rx shares bits with rrr.rx
	// store data rz read on port 1 in the second half
	assign rd_idx1_o = (is_sw && sw_phase_q) ? ifid_q.rrr.rz : ifid_q.rrr.rx;
	assign rd_idx2_o = ifid_q.rrr.ry;

	always_comb begin
		idex_o = '0;
		case (ifid_q.rrr.opcode)
			OP_LI: begin
				idex_o.valid    = 1'b1;
				idex_o.regwrite = 1'b1;
				idex_o.aluop    = ALU_PASSB;
				idex_o.opb      = imm_zext;
				idex_o.rd       = ifid_q.ri.rx;
			end
			OP_ADDIU: begin
				idex_o.valid    = 1'b1;
				idex_o.regwrite = 1'b1;
				idex_o.aluop    = ALU_ADD;
				idex_o.opa      = rd_data1_i;
				idex_o.rs1      = ifid_q.ri.rx;
				idex_o.rs1_used = 1'b1;
				idex_o.opb      = imm_sext;
				idex_o.rd       = ifid_q.ri.rx;
			end
			OP_ALU: begin
				idex_o.valid    = 1'b1;
				idex_o.regwrite = 1'b1;
				idex_o.opa      = rd_data1_i;
				idex_o.rs1      = ifid_q.rrr.rx;
				idex_o.rs1_used = 1'b1;
				idex_o.opb      = rd_data2_i;
				idex_o.rs2      = ifid_q.rrr.ry;
				idex_o.rs2_used = 1'b1;
				idex_o.rd       = ifid_q.rrr.rz;
				case (ifid_q.rrr.funct)
					F_ADDU:  idex_o.aluop = ALU_ADD;
					F_SUBU:  idex_o.aluop = ALU_SUB;
					F_AND:   idex_o.aluop = ALU_AND;
					default: idex_o.aluop = ALU_OR;
				endcase
			end
			OP_LW: begin
				idex_o.valid    = 1'b1;
				idex_o.regwrite = 1'b1;
				idex_o.memread  = 1'b1;
				idex_o.aluop    = ALU_ADD;
				idex_o.opa      = rd_data1_i;
				idex_o.rs1      = ifid_q.rrr.rx;
				idex_o.rs1_used = 1'b1;
				idex_o.opb      = rd_data2_i;
				idex_o.rs2      = ifid_q.rrr.ry;
				idex_o.rs2_used = 1'b1;
				idex_o.rd       = ifid_q.rrr.rz;
			end
			OP_SW: begin
				idex_o.valid = 1'b1;
				if (!sw_phase_q) begin
					// first half, address rx + ry, no write
					idex_o.aluop    = ALU_ADD;
					idex_o.opa      = rd_data1_i;
					idex_o.rs1      = ifid_q.rrr.rx;
					idex_o.rs1_used = 1'b1;
					idex_o.opb      = rd_data2_i;
					idex_o.rs2      = ifid_q.rrr.ry;
					idex_o.rs2_used = 1'b1;
				end else begin
					// second half picks address from ex/mem
					idex_o.memwrite = 1'b1;
					idex_o.aluop    = ALU_PASSB;
					idex_o.b_prev   = 1'b1;
					idex_o.rs_st    = ifid_q.rrr.rz;
					idex_o.st_data  = rd_data1_i;
				end
			end
			// nop and unknown words leave an empty bundle
			default: idex_o = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// load-use detection
	////////////////////////////////////////////////////////////
	assign hit1 = idex_o.rs1_used && (idex_o.rs1 == idex_fb_i.rd);
	assign hit2 = idex_o.rs2_used && (idex_o.rs2 == idex_fb_i.rd);

	// load one stage ahead, data not ready until wb
	// store data half always trails its own address half, reaches the load by wb
	assign stall_o = idex_fb_i.valid & idex_fb_i.memread & (hit1 | hit2);

endmodule

// ==== hdl/zzcpu_id_ex.sv ====
`timescale 1ns/1ns
`include "zzcpu_params.svh"

module zzcpu_id_ex
	import zzcpu_pipe_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n_i,
	input  idex_t idex_i,
	input  logic  stall_i,
	output idex_t idex_o
);

	idex_t idex_q;

	////////////////////////////////////////////////////////////
	// id/ex register
	////////////////////////////////////////////////////////////

	// bubble on stall
	// all-zero bundle has valid and every write strobe low
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			idex_q <= '0;
		end else if (stall_i) begin
			idex_q <= '0;
		end else begin
			idex_q <= idex_i;
		end
	end

	assign idex_o = idex_q;

endmodule

// ==== hdl/zzcpu_isa_pkg.sv ====
`include "zzcpu_params.svh"

package zzcpu_isa_pkg;

	////////////////////////////////////////////////////////////
	// opcodes, top five bits of every word
	////////////////////////////////////////////////////////////
	typedef enum logic [4:0] {
		OP_NOP   = 5'b00000,
		OP_ADDIU = 5'b01001,
		OP_LI    = 5'b01101,
		OP_LW    = 5'b10011,
		OP_SW    = 5'b11011,
		OP_ALU   = 5'b11100
	} opcode_e;

	// low two bits under OP_ALU
	typedef enum logic [1:0] {
		F_AND  = 2'b00,
		F_ADDU = 2'b01,
		F_OR   = 2'b10,
		F_SUBU = 2'b11
	} funct_e;

	typedef logic [`ZZCPU_REG_AW-1:0] reg_idx_t;
	typedef logic [7:0] imm_t;

	// three register form
	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rx;
		reg_idx_t ry;
		reg_idx_t rz;
		funct_e   funct;
	} instr_rrr_t;

	// register plus immediate form
	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rx;
		imm_t     imm;
	} instr_ri_t;

	// same word, view picked by opcode
	typedef union packed {
		instr_rrr_t rrr;
		instr_ri_t  ri;
	} instr_u;

endpackage

// ==== hdl/zzcpu_memory_wb.sv ====
`timescale 1ns/1ns
`include "zzcpu_params.svh"

module zzcpu_memory_wb
	import zzcpu_pipe_pkg::*;
(
	input  logic                      clk,
	input  logic                      arst_n_i,
	input  exmem_t                    exmem_i,
	output logic [`ZZCPU_DADDR_W-1:0] ram1_addr_o,
	output logic [`ZZCPU_XLEN-1:0]    ram1_wdata_o,
	input  logic [`ZZCPU_XLEN-1:0]    ram1_rdata_i,
	output logic                      ram1_oe_n_o,
	output logic                      ram1_we_n_o,
	output logic [`ZZCPU_XLEN-1:0]    light_o,
	output wb_t                       wb_o
);

	memwb_t memwb_q;
	memwb_t memwb_d;

	////////////////////////////////////////////////////////////
	// sram port
	////////////////////////////////////////////////////////////

	// upper address bits stay low
	assign ram1_addr_o  = {{(`ZZCPU_DADDR_W-`ZZCPU_XLEN){1'b0}}, exmem_i.result};
	assign ram1_wdata_o = exmem_i.st_data;

	// strobes active low, one mem cycle each
	assign ram1_oe_n_o = ~(exmem_i.valid & exmem_i.memread);
	assign ram1_we_n_o = ~(exmem_i.valid & exmem_i.memwrite);

	// last stored word shown on the lights
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			light_o <= '0;
		end else if (exmem_i.valid && exmem_i.memwrite) begin
			light_o <= exmem_i.st_data;
		end
	end

	////////////////////////////////////////////////////////////
	// mem/wb register and writeback select
	////////////////////////////////////////////////////////////
	always_comb begin
		memwb_d          = '0;
		memwb_d.valid    = exmem_i.valid;
		memwb_d.regwrite = exmem_i.regwrite;
		memwb_d.memtoreg = exmem_i.memread;
		memwb_d.alu_res  = exmem_i.result;
		memwb_d.mem_res  = ram1_rdata_i;
		memwb_d.rd       = exmem_i.rd;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			memwb_q <= '0;
		end else begin
			memwb_q <= memwb_d;
		end
	end

	assign wb_o.en   = memwb_q.valid & memwb_q.regwrite;
	assign wb_o.rd   = memwb_q.rd;
	assign wb_o.data = memwb_q.memtoreg ? memwb_q.mem_res : memwb_q.alu_res;

endmodule

// ==== hdl/zzcpu_pipe_pkg.sv ====
`include "zzcpu_params.svh"

package zzcpu_pipe_pkg;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_PASSB
	} alu_op_e;

	////////////////////////////////////////////////////////////
	// stage bundles
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic                     valid;
		logic                     regwrite;
		logic                     memread;
		logic                     memwrite;
		alu_op_e                  aluop;
		logic [`ZZCPU_XLEN-1:0]   opa;
		logic [`ZZCPU_XLEN-1:0]   opb;
		logic [`ZZCPU_REG_AW-1:0] rs1;
		logic                     rs1_used;
		logic [`ZZCPU_REG_AW-1:0] rs2;
		logic                     rs2_used;
		// operand b is the result now sitting in ex/mem
		logic                     b_prev;
		logic [`ZZCPU_REG_AW-1:0] rs_st;
		logic [`ZZCPU_XLEN-1:0]   st_data;
		logic [`ZZCPU_REG_AW-1:0] rd;
	} idex_t;

	typedef struct packed {
		logic                     valid;
		logic                     regwrite;
		logic                     memread;
		logic                     memwrite;
		logic [`ZZCPU_XLEN-1:0]   result;
		logic [`ZZCPU_XLEN-1:0]   st_data;
		logic [`ZZCPU_REG_AW-1:0] rd;
	} exmem_t;

	typedef struct packed {
		logic                     valid;
		logic                     regwrite;
		logic                     memtoreg;
		logic [`ZZCPU_XLEN-1:0]   alu_res;
		logic [`ZZCPU_XLEN-1:0]   mem_res;
		logic [`ZZCPU_REG_AW-1:0] rd;
	} memwb_t;

	// to register file and forwarding
	typedef struct packed {
		logic                     en;
		logic [`ZZCPU_REG_AW-1:0] rd;
		logic [`ZZCPU_XLEN-1:0]   data;
	} wb_t;

endpackage

// ==== hdl/zzcpu_regheap.sv ====
`timescale 1ns/1ns
`include "zzcpu_params.svh"

module zzcpu_regheap
	import zzcpu_pipe_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic [`ZZCPU_REG_AW-1:0] rd_idx1_i,
	input  logic [`ZZCPU_REG_AW-1:0] rd_idx2_i,
	output logic [`ZZCPU_XLEN-1:0]   rd_data1_o,
	output logic [`ZZCPU_XLEN-1:0]   rd_data2_o,
	input  wb_t                      wb_i
);

	logic [`ZZCPU_XLEN-1:0] regs_q [`ZZCPU_NREG];

	// write-through, same-cycle writeback wins
	function automatic logic [`ZZCPU_XLEN-1:0] rd_port(
		input logic [`ZZCPU_REG_AW-1:0] idx
	);
		if (wb_i.en && (wb_i.rd == idx)) begin
			return wb_i.data;
		end
		return regs_q[idx];
	endfunction

	always_comb begin
		rd_data1_o = rd_port(rd_idx1_i);
		rd_data2_o = rd_port(rd_idx2_i);
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `ZZCPU_NREG; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wb_i.en) begin
			regs_q[wb_i.rd] <= wb_i.data;
		end
	end

endmodule

// ==== include/zzcpu_params.svh ====
`ifndef ZZCPU_PARAMS_SVH
`define ZZCPU_PARAMS_SVH

// data path width
`define ZZCPU_XLEN 16

// general register count and index width
`define ZZCPU_NREG 8
`define ZZCPU_REG_AW 3

// word address into instruction memory
`define ZZCPU_PC_W 16

// sram address, top two bits tied low
`define ZZCPU_DADDR_W 18

`endif

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the zzcpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module zzcpu_tb -f zzcpu.f -o zzcpu_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/zzcpu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1

// ==== testbench/zzcpu_tb.sv ====
`timescale 1ns/1ns
`include "zzcpu_params.svh"

module zzcpu_tb
	import zzcpu_isa_pkg::*;
();

	localparam int NUM_TESTS   = 5;
	// per test budget of program length plus slack, 8 ns period
	localparam int WATCHDOG_NS = NUM_TESTS * (64 + 30) * 8;

	logic                      clk;
	logic                      arst_n_i;
	logic [`ZZCPU_PC_W-1:0]    imem_addr;
	logic [`ZZCPU_XLEN-1:0]    imem_data;
	logic [`ZZCPU_DADDR_W-1:0] ram_addr;
	logic [`ZZCPU_XLEN-1:0]    ram_wdata;
	logic [`ZZCPU_XLEN-1:0]    ram_rdata;
	logic                      ram_oe_n;
	logic                      ram_we_n;
	logic [`ZZCPU_XLEN-1:0]    light;

	// instruction and data memories
	logic [15:0] imem [64];
	logic [15:0] dmem [256];
	logic        dmem_init;

	// expected stores from the reference, in order
	logic [17:0] exp_addr [$];
	logic [15:0] exp_data [$];

	int     prog_len;
	int     store_cnt;
	int     err_cnt;
	int     check_cnt;
	int     fail_tests;
	int     test_num;
	integer seed;

	always #4 clk = ~clk;

	zzcpu zzcpu_i (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.imem_addr_o  (imem_addr),
		.imem_data_i  (imem_data),
		.ram1_addr_o  (ram_addr),
		.ram1_wdata_o (ram_wdata),
		.ram1_rdata_i (ram_rdata),
		.ram1_oe_n_o  (ram_oe_n),
		.ram1_we_n_o  (ram_we_n),
		.light_o      (light)
	);

	////////////////////////////////////////////////////////////
	// memory models
	////////////////////////////////////////////////////////////

	// past the 64-word program everything reads as nop
	assign imem_data = (imem_addr[15:6] == '0) ? imem[imem_addr[5:0]] : '0;
	assign ram_rdata = ram_oe_n ? '0 : dmem[ram_addr[7:0]];

	// sram write on rising edge, refill while a test is in reset
	always @(posedge clk) begin
		if (dmem_init) begin
			for (int i = 0; i < 256; i++) begin
				dmem[i] <= fill_word(8'(i));
			end
		end else if (!ram_we_n) begin
			dmem[ram_addr[7:0]] <= ram_wdata;
		end
	end

	// every address bit shows up in the word
	function automatic logic [15:0] fill_word(input logic [7:0] a);
		return {a, ~a};
	endfunction

	////////////////////////////////////////////////////////////
	// instruction encoding and reference
	////////////////////////////////////////////////////////////
	function automatic logic [15:0] rrr_word(input logic [4:0] op, input logic [2:0] x,
		input logic [2:0] y, input logic [2:0] z, input logic [1:0] f);
		return {op, x, y, z, f};
	endfunction

	function automatic logic [15:0] ri_word(input logic [4:0] op, input logic [2:0] x,
		input logic [7:0] imm);
		return {op, x, imm};
	endfunction

	function automatic void emit(input logic [15:0] w);
		imem[prog_len] = w;
		prog_len++;
	endfunction

	// sequential interpreter, one instruction at a time
	function automatic void ref_run();
		logic [15:0] r [8];
		logic [15:0] m [256];
		logic [15:0] w;
		logic [15:0] a;
		exp_addr.delete();
		exp_data.delete();
		for (int i = 0; i < 8; i++) begin
			r[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			m[i] = fill_word(8'(i));
		end
		for (int pc = 0; pc < prog_len; pc++) begin
			w = imem[pc];
			a = r[w[10:8]] + r[w[7:5]];
			case (w[15:11])
				OP_LI:    r[w[10:8]] = {8'h00, w[7:0]};
				OP_ADDIU: r[w[10:8]] = r[w[10:8]] + {{8{w[7]}}, w[7:0]};
				OP_ALU: begin
					case (w[1:0])
						F_ADDU:  r[w[4:2]] = r[w[10:8]] + r[w[7:5]];
						F_SUBU:  r[w[4:2]] = r[w[10:8]] - r[w[7:5]];
						F_AND:   r[w[4:2]] = r[w[10:8]] & r[w[7:5]];
						default: r[w[4:2]] = r[w[10:8]] | r[w[7:5]];
					endcase
				end
				OP_LW: r[w[4:2]] = m[a[7:0]];
				OP_SW: begin
					m[a[7:0]] = r[w[4:2]];
					exp_addr.push_back({2'b00, a});
					exp_data.push_back(r[w[4:2]]);
				end
				default: ;
			endcase
		end
	endfunction

	////////////////////////////////////////////////////////////
	// checking
	////////////////////////////////////////////////////////////
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_cnt++;
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	// store strobe is stable by the falling edge
	always @(negedge clk) begin
		if (ram_we_n === 1'b0) begin
			if (store_cnt < exp_addr.size()) begin
				check("ram1_addr_o", 32'(ram_addr), 32'(exp_addr[store_cnt]));
				check("ram1_wdata_o", 32'(ram_wdata), 32'(exp_data[store_cnt]));
			end else begin
				$display("store %0d at %0t ns has no matching reference store",
					store_cnt + 1, $time);
				err_cnt++;
			end
			store_cnt++;
		end
	end

	task automatic hold_reset();
		@(negedge clk);
		arst_n_i  = 1'b0;
		dmem_init = 1'b1;
		store_cnt = 0;
		prog_len  = 0;
		for (int i = 0; i < 64; i++) begin
			imem[i] = '0;
		end
	endtask

	task automatic run_program(input string name, input logic light_chk);
		int errs_before;
		errs_before = err_cnt;
		test_num++;
		ref_run();
		repeat (10) @(negedge clk);
		dmem_init = 1'b0;
		// reset state
		check("imem_addr_o", 32'(imem_addr), 32'h0);
		check("ram1_we_n_o", 32'(ram_we_n), 32'h1);
		check("ram1_oe_n_o", 32'(ram_oe_n), 32'h1);
		check("light_o", 32'(light), 32'h0);
		arst_n_i = 1'b1;
		// done once the pc is four nops past the program
		while (32'(imem_addr) != prog_len + 4) begin
			@(negedge clk);
		end
		@(negedge clk);
		if (store_cnt != exp_data.size()) begin
			$display("test %0d made %0d stores but the reference made %0d",
				test_num, store_cnt, exp_data.size());
			err_cnt++;
		end
		if (light_chk && exp_data.size() > 0) begin
			check("light_o", 32'(light), 32'(exp_data[exp_data.size() - 1]));
		end
		if (err_cnt != errs_before) begin
			fail_tests++;
		end
		$display("test %0d %s: %s, %0d stores", test_num, name,
			(err_cnt == errs_before) ? "ok" : "failed", store_cnt);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run still going after %0d ns", WATCHDOG_NS);
		$display("*** FAILED ***");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////
	initial begin
		logic [31:0] rnd;
		clk        = 1'b0;
		arst_n_i   = 1'b0;
		dmem_init  = 1'b1;
		seed       = 32'h00216e95;
		err_cnt    = 0;
		check_cnt  = 0;
		fail_tests = 0;
		test_num   = 0;
		store_cnt  = 0;
		prog_len   = 0;
		for (int i = 0; i < 64; i++) begin
			imem[i] = '0;
		end

		// alu chain, each result feeds the next
		hold_reset();
		emit(ri_word(OP_LI, 1, 8'h35));
		emit(ri_word(OP_LI, 2, 8'h0c));
		emit(rrr_word(OP_ALU, 1, 2, 3, F_ADDU));
		emit(rrr_word(OP_ALU, 3, 1, 4, F_SUBU));
		emit(rrr_word(OP_ALU, 3, 4, 5, F_OR));
		emit(rrr_word(OP_ALU, 5, 4, 6, F_AND));
		emit(rrr_word(OP_ALU, 6, 5, 7, F_SUBU));
		emit(rrr_word(OP_SW, 0, 0, 7, 2'b00));
		emit(rrr_word(OP_SW, 0, 2, 6, 2'b00));
		emit(rrr_word(OP_SW, 0, 1, 5, 2'b00));
		emit(rrr_word(OP_SW, 0, 3, 4, 2'b00));
		run_program("alu forwarding", 1'b0);

		// zero extend on li, sign extend on addiu
		hold_reset();
		emit(ri_word(OP_LI, 1, 8'hc8));
		emit(ri_word(OP_ADDIU, 1, 8'hf0));
		emit(ri_word(OP_LI, 2, 8'h80));
		emit(ri_word(OP_ADDIU, 2, 8'h85));
		emit(ri_word(OP_LI, 3, 8'h00));
		emit(ri_word(OP_ADDIU, 3, 8'hff));
		emit(rrr_word(OP_SW, 0, 0, 1, 2'b00));
		emit(rrr_word(OP_SW, 0, 2, 3, 2'b00));
		emit(ri_word(OP_ADDIU, 3, 8'h7f));
		emit(rrr_word(OP_SW, 2, 2, 3, 2'b00));
		run_program("immediate extension", 1'b0);

		// load then use at once, as operand, store data and address
		hold_reset();
		emit(ri_word(OP_LI, 1, 8'h10));
		emit(ri_word(OP_LI, 2, 8'h04));
		emit(rrr_word(OP_LW, 1, 2, 3, 2'b00));
		emit(rrr_word(OP_ALU, 3, 1, 4, F_ADDU));
		emit(rrr_word(OP_SW, 0, 1, 4, 2'b00));
		emit(rrr_word(OP_LW, 2, 2, 5, 2'b00));
		emit(rrr_word(OP_SW, 0, 2, 5, 2'b00));
		emit(rrr_word(OP_LW, 0, 1, 6, 2'b00));
		emit(rrr_word(OP_LW, 6, 0, 7, 2'b00));
		emit(rrr_word(OP_SW, 0, 0, 7, 2'b00));
		run_program("load-use stall", 1'b0);

		// store, load back, modify, store again
		hold_reset();
		emit(ri_word(OP_LI, 1, 8'h40));
		emit(ri_word(OP_LI, 2, 8'ha5));
		emit(rrr_word(OP_SW, 1, 0, 2, 2'b00));
		emit(rrr_word(OP_LW, 1, 0, 3, 2'b00));
		emit(ri_word(OP_ADDIU, 3, 8'h01));
		emit(rrr_word(OP_SW, 0, 1, 3, 2'b00));
		emit(rrr_word(OP_LW, 0, 1, 4, 2'b00));
		emit(rrr_word(OP_SW, 1, 1, 4, 2'b00));
		run_program("memory round trip", 1'b1);

		// random mix, then dump all eight registers
		hold_reset();
		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			case (rnd[2:0])
				3'd0: emit(ri_word(OP_LI, rnd[10:8], rnd[23:16]));
				3'd1: emit(ri_word(OP_ADDIU, rnd[10:8], rnd[23:16]));
				3'd6: emit(rrr_word(OP_LW, rnd[10:8], rnd[13:11], rnd[16:14], 2'b00));
				3'd7: emit(rrr_word(OP_SW, rnd[10:8], rnd[13:11], rnd[16:14], 2'b00));
				default: emit(rrr_word(OP_ALU, rnd[10:8], rnd[13:11], rnd[16:14], rnd[4:3]));
			endcase
		end
		for (int k = 0; k < 8; k++) begin
			emit(rrr_word(OP_SW, 3'(k), 3'((k + 3) % 8), 3'(k), 2'b00));
		end
		run_program("random program", 1'b0);

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			test_num, fail_tests, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== zzcpu.f ====
+incdir+include
hdl/zzcpu_isa_pkg.sv
hdl/zzcpu_pipe_pkg.sv
hdl/zzcpu_fetch_decode.sv
hdl/zzcpu_regheap.sv
hdl/zzcpu_id_ex.sv
hdl/zzcpu_execute.sv
hdl/zzcpu_memory_wb.sv
hdl/zzcpu.sv
testbench/zzcpu_tb.sv
